// File: files.f
+incdir+tb
logic/regReadPkg.sv
logic/physRegFile.sv
logic/bypassSelect.sv
logic/readyTable.sv
logic/regRead.sv
tb/regReadTb.sv

// File: Bender.yml
package:
  name: regRead

sources:
  - files:
      - logic/regReadPkg.sv
      - logic/physRegFile.sv
      - logic/bypassSelect.sv
      - logic/readyTable.sv
      - logic/regRead.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/regReadTb.sv

// File: tb/regReadVectors.svh
// --------------------------------------------------
// Stimulus and expected-value rows for the testbench
// One row per cycle, grouped by test number
// --------------------------------------------------

`ifndef REG_READ_VECTORS_SVH
`define REG_READ_VECTORS_SVH

// Each row holds the test number, issue lanes, bypass lanes, branch, ready updates,
// expected opValid and expected ready vector
task automatic loadVectors();
  rowT r;
  // Test 1 checks the reset pattern
  r = blankRow(1);
  r.chkRdy = 1'b1;
  r.expRdy = ArchRdy;
  vecs.push_back(r);
  // Test 2 writes 40..43, reads them back, then tries a write under recovery
  r = blankRow(2);
  r.bypValid = 4'hF;
  r.bypDest = {6'd43, 6'd42, 6'd41, 6'd40};
  vecs.push_back(r);
  r = blankRow(2);
  r.instValid = 4'hF;
  r.expOpValid = 4'hF;
  r.src1 = {6'd43, 6'd42, 6'd41, 6'd40};
  r.src2 = {6'd40, 6'd43, 6'd42, 6'd41};
  vecs.push_back(r);
  r = blankRow(2);
  r.bypValid = 4'h1;
  r.bypDest[0] = 6'd40;
  r.recover = 1'b1;
  vecs.push_back(r);
  r = blankRow(2);
  r.src1 = {4{6'd40}};
  r.src2 = {4{6'd40}};
  vecs.push_back(r);
  // Test 3 forwards with recovery high and low
  r = blankRow(3);
  r.bypValid = 4'h4;
  r.bypDest[2] = 6'd44;
  r.recover = 1'b1;
  r.src1 = {6'd44, 6'd41, 6'd44, 6'd42};
  r.src2 = {6'd40, 6'd44, 6'd43, 6'd44};
  vecs.push_back(r);
  r = blankRow(3);
  r.bypValid = 4'h2;
  r.bypDest[1] = 6'd45;
  r.src1 = {6'd45, 6'd40, 6'd45, 6'd41};
  r.src2 = {6'd42, 6'd45, 6'd43, 6'd45};
  vecs.push_back(r);
  r = blankRow(3);
  r.src1 = {4{6'd45}};
  r.src2 = {4{6'd41}};
  vecs.push_back(r);
  // Test 4 squashes lanes that depend on the mispredicted checkpoint
  r = blankRow(4);
  r.instValid = 4'hF;
  r.verified = 1'b1;
  r.mispredict = 1'b1;
  r.ckpt = 2'd2;
  r.mask = {4'b1000, 4'b0110, 4'b0001, 4'b0100};
  r.expOpValid = 4'b1010;
  vecs.push_back(r);
  r = blankRow(4);
  r.instValid = 4'hF;
  r.mispredict = 1'b1;
  r.ckpt = 2'd2;
  r.mask = {4'b1000, 4'b0110, 4'b0001, 4'b0100};
  r.expOpValid = 4'hF;
  vecs.push_back(r);
  r = blankRow(4);
  r.instValid = 4'b0111;
  r.verified = 1'b1;
  r.mispredict = 1'b1;
  r.mask = {4'b0001, 4'b0001, 4'b0010, 4'b0001};
  r.expOpValid = 4'b0010;
  vecs.push_back(r);
  // Test 5 walks the ready table through unmap, wakeup and exception
  r = blankRow(5);
  r.unmapValid = 4'b0011;
  r.unmapTag[0] = 6'd5;
  r.unmapTag[1] = 6'd10;
  r.wakeValid = 4'b0001;
  r.wakeTag[0] = 6'd50;
  r.chkRdy = 1'b1;
  r.expRdy = ArchRdy;
  vecs.push_back(r);
  r = blankRow(5);
  r.unmapValid = 4'b0011;
  r.unmapTag[0] = 6'd50;
  r.unmapTag[1] = 6'd7;
  r.wakeValid = 4'b0100;
  r.wakeTag[2] = 6'd50;
  r.chkRdy = 1'b1;
  r.expRdy = 64'h0004_0000_FFFF_FBDF;
  vecs.push_back(r);
  r = blankRow(5);
  r.wakeValid = 4'b1000;
  r.wakeTag[3] = 6'd5;
  r.chkRdy = 1'b1;
  r.expRdy = 64'h0004_0000_FFFF_FB5F;
  vecs.push_back(r);
  r = blankRow(5);
  r.exceptionFlag = 1'b1;
  r.chkRdy = 1'b1;
  r.expRdy = 64'h0004_0000_FFFF_FB7F;
  vecs.push_back(r);
  r = blankRow(5);
  r.chkRdy = 1'b1;
  r.expRdy = ArchRdy;
  vecs.push_back(r);
endtask

`endif

// File: tb/regReadTb.sv
// --------------------------------------------------
// Testbench for the register-read stage
// Clock, reset, row table loop, checks, watchdog
// --------------------------------------------------

`timescale 1ns/1ps

module regReadTb;

  localparam logic [63:0] ArchRdy = 64'h0000_0000_FFFF_FFFF;

  typedef struct packed {
    logic [2:0]      test;
    logic [3:0]      instValid;
    logic [3:0][5:0] src1;
    logic [3:0][5:0] src2;
    logic [3:0][3:0] mask;
    logic [3:0]      bypValid;
    logic [3:0][5:0] bypDest;
    logic            recover;
    logic            verified;
    logic            mispredict;
    logic [1:0]      ckpt;
    logic [3:0]      unmapValid;
    logic [3:0][5:0] unmapTag;
    logic [3:0]      wakeValid;
    logic [3:0][5:0] wakeTag;
    logic            exceptionFlag;
    logic [3:0]      expOpValid;
    logic            chkRdy;
    logic [63:0]     expRdy;
  } rowT;

  logic clk, rst_i, recoverFlag_i, ctrlVerified_i, ctrlMispredict_i, exceptionFlag_i;
  logic [1:0] ctrlCheckpoint_i;
  logic instValid0_i, instValid1_i, instValid2_i, instValid3_i;
  logic [5:0] inst0Src1_i, inst1Src1_i, inst2Src1_i, inst3Src1_i;
  logic [5:0] inst0Src2_i, inst1Src2_i, inst2Src2_i, inst3Src2_i;
  logic [3:0] inst0Mask_i, inst1Mask_i, inst2Mask_i, inst3Mask_i;
  logic bypassValid0_i, bypassValid1_i, bypassValid2_i, bypassValid3_i;
  logic [5:0] bypassDest0_i, bypassDest1_i, bypassDest2_i, bypassDest3_i;
  logic [31:0] bypassData0_i, bypassData1_i, bypassData2_i, bypassData3_i;
  logic unmapValid0_i, unmapValid1_i, unmapValid2_i, unmapValid3_i;
  logic [5:0] unmapTag0_i, unmapTag1_i, unmapTag2_i, unmapTag3_i;
  logic wakeValid0_i, wakeValid1_i, wakeValid2_i, wakeValid3_i;
  logic [5:0] wakeTag0_i, wakeTag1_i, wakeTag2_i, wakeTag3_i;
  logic opValid0_o, opValid1_o, opValid2_o, opValid3_o;
  logic [31:0] op0Data1_o, op1Data1_o, op2Data1_o, op3Data1_o;
  logic [31:0] op0Data2_o, op1Data2_o, op2Data2_o, op3Data2_o;
  logic [63:0] phyRegRdy_o;

  rowT              vecs[$];
  logic [31:0]      shadow [64];
  logic [63:0]      known;
  logic [31:0]      rngState;
  logic [3:0][31:0] rowData;
  int               errors;
  int               checks;
  int               testErrors;

  regRead regRead_i (.*);

  function automatic rowT blankRow(input int test);
    rowT r;
    r = '0;
    r.test = 3'(test);
    return r;
  endfunction

  `include "regReadVectors.svh"

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic checkValue(input logic [63:0] got, input logic [63:0] expected,
                            input string what);
    checks++;
    if (got !== expected) begin
      errors++;
      testErrors++;
      $display("[FAIL] %0t ns: %s got %0h expected %0h", $time, what, got, expected);
    end
  endtask

  task automatic driveRow(input rowT r);
    for (int n = 0; n < 4; n++) begin
      rngState = xorshift(rngState);
      rowData[n] = rngState;
    end
    {instValid3_i, instValid2_i, instValid1_i, instValid0_i} = r.instValid;
    {inst3Src1_i, inst2Src1_i, inst1Src1_i, inst0Src1_i} = r.src1;
    {inst3Src2_i, inst2Src2_i, inst1Src2_i, inst0Src2_i} = r.src2;
    {inst3Mask_i, inst2Mask_i, inst1Mask_i, inst0Mask_i} = r.mask;
    {bypassValid3_i, bypassValid2_i, bypassValid1_i, bypassValid0_i} = r.bypValid;
    {bypassDest3_i, bypassDest2_i, bypassDest1_i, bypassDest0_i} = r.bypDest;
    {bypassData3_i, bypassData2_i, bypassData1_i, bypassData0_i} = rowData;
    {unmapValid3_i, unmapValid2_i, unmapValid1_i, unmapValid0_i} = r.unmapValid;
    {unmapTag3_i, unmapTag2_i, unmapTag1_i, unmapTag0_i} = r.unmapTag;
    {wakeValid3_i, wakeValid2_i, wakeValid1_i, wakeValid0_i} = r.wakeValid;
    {wakeTag3_i, wakeTag2_i, wakeTag1_i, wakeTag0_i} = r.wakeTag;
    recoverFlag_i = r.recover;
    ctrlVerified_i = r.verified;
    ctrlMispredict_i = r.mispredict;
    ctrlCheckpoint_i = r.ckpt;
    exceptionFlag_i = r.exceptionFlag;
  endtask

  // A valid bypass on the tag gives the expected operand, else the last committed write
  task automatic checkRow(input rowT r);
    logic [7:0][31:0] got;
    logic [5:0]       tag;
    logic             fwd;
    logic [31:0]      expected;
    got = {op3Data2_o, op3Data1_o, op2Data2_o, op2Data1_o,
           op1Data2_o, op1Data1_o, op0Data2_o, op0Data1_o};
    checkValue({opValid3_o, opValid2_o, opValid1_o, opValid0_o}, r.expOpValid, "opValid");
    for (int p = 0; p < 8; p++) begin
      tag = p[0] ? r.src2[p/2] : r.src1[p/2];
      fwd = 1'b0;
      expected = shadow[tag];
      for (int n = 0; n < 4; n++) begin
        if (r.bypValid[n] && r.bypDest[n] == tag) begin
          fwd = 1'b1;
          expected = rowData[n];
        end
      end
      if (fwd || known[tag]) begin
        checkValue(got[p], expected, $sformatf("lane %0d operand %0d", p / 2, p % 2 + 1));
      end
    end
    if (r.chkRdy) begin
      checkValue(phyRegRdy_o, r.expRdy, "phyRegRdy");
    end
    // Writes under recovery never reach the file
    for (int n = 0; n < 4; n++) begin
      if (r.bypValid[n] && !r.recover) begin
        shadow[r.bypDest[n]] = rowData[n];
        known[r.bypDest[n]] = 1'b1;
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    longint limit;
    #1;
    limit = (vecs.size() + 16 + 10) * 20;
    #(limit);
    $display("Watchdog: the run timed out before all rows were applied");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    errors = 0;
    checks = 0;
    testErrors = 0;
    known = '0;
    rngState = 32'd66;
    rst_i = 1'b1;
    driveRow(blankRow(0));
    loadVectors();
    repeat (16) @(posedge clk);
    #2 rst_i = 1'b0;
    foreach (vecs[i]) begin
      @(posedge clk);
      #2 driveRow(vecs[i]);
      #16 checkRow(vecs[i]);
      if (i == vecs.size() - 1 || vecs[i+1].test != vecs[i].test) begin
        $display("Test %0d finished with %0d errors", vecs[i].test, testErrors);
        testErrors = 0;
      end
    end
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: logic/regRead.sv
// --------------------------------------------------
// Register-read stage of the four-lane core
// Register file, operand bypass, ready scoreboard
// and mispredict squash of issued lanes
// --------------------------------------------------

`timescale 1ns/1ps

module regRead #(
  parameter int NumPhysRegs = regReadPkg::DefPhysRegs,
  parameter int NumArchRegs = regReadPkg::DefArchRegs,
  parameter int DataWidth = regReadPkg::DefDataWidth,
  parameter int NumCheckpoints = regReadPkg::DefCheckpoints,
  localparam int TagWidth = $clog2(NumPhysRegs),
  localparam int CkptWidth = $clog2(NumCheckpoints)
) (
  input  logic                      clk,
  input  logic                      rst_i,
  // Issue lanes
  input  logic                      instValid0_i,
  input  logic [TagWidth-1:0]       inst0Src1_i,
  input  logic [TagWidth-1:0]       inst0Src2_i,
  input  logic [NumCheckpoints-1:0] inst0Mask_i,
  input  logic                      instValid1_i,
  input  logic [TagWidth-1:0]       inst1Src1_i,
  input  logic [TagWidth-1:0]       inst1Src2_i,
  input  logic [NumCheckpoints-1:0] inst1Mask_i,
  input  logic                      instValid2_i,
  input  logic [TagWidth-1:0]       inst2Src1_i,
  input  logic [TagWidth-1:0]       inst2Src2_i,
  input  logic [NumCheckpoints-1:0] inst2Mask_i,
  input  logic                      instValid3_i,
  input  logic [TagWidth-1:0]       inst3Src1_i,
  input  logic [TagWidth-1:0]       inst3Src2_i,
  input  logic [NumCheckpoints-1:0] inst3Mask_i,
  // Bypass lanes
  input  logic                      bypassValid0_i,
  input  logic [TagWidth-1:0]       bypassDest0_i,
  input  logic [DataWidth-1:0]      bypassData0_i,
  input  logic                      bypassValid1_i,
  input  logic [TagWidth-1:0]       bypassDest1_i,
  input  logic [DataWidth-1:0]      bypassData1_i,
  input  logic                      bypassValid2_i,
  input  logic [TagWidth-1:0]       bypassDest2_i,
  input  logic [DataWidth-1:0]      bypassData2_i,
  input  logic                      bypassValid3_i,
  input  logic [TagWidth-1:0]       bypassDest3_i,
  input  logic [DataWidth-1:0]      bypassData3_i,
  input  logic                      recoverFlag_i,
  // Branch resolution
  input  logic                      ctrlVerified_i,
  input  logic                      ctrlMispredict_i,
  input  logic [CkptWidth-1:0]      ctrlCheckpoint_i,
  // Ready table updates
  input  logic                      unmapValid0_i,
  input  logic [TagWidth-1:0]       unmapTag0_i,
  input  logic                      unmapValid1_i,
  input  logic [TagWidth-1:0]       unmapTag1_i,
  input  logic                      unmapValid2_i,
  input  logic [TagWidth-1:0]       unmapTag2_i,
  input  logic                      unmapValid3_i,
  input  logic [TagWidth-1:0]       unmapTag3_i,
  input  logic                      wakeValid0_i,
  input  logic [TagWidth-1:0]       wakeTag0_i,
  input  logic                      wakeValid1_i,
  input  logic [TagWidth-1:0]       wakeTag1_i,
  input  logic                      wakeValid2_i,
  input  logic [TagWidth-1:0]       wakeTag2_i,
  input  logic                      wakeValid3_i,
  input  logic [TagWidth-1:0]       wakeTag3_i,
  input  logic                      exceptionFlag_i,
  // Operands to the functional units
  output logic                      opValid0_o,
  output logic [DataWidth-1:0]      op0Data1_o,
  output logic [DataWidth-1:0]      op0Data2_o,
  output logic                      opValid1_o,
  output logic [DataWidth-1:0]      op1Data1_o,
  output logic [DataWidth-1:0]      op1Data2_o,
  output logic                      opValid2_o,
  output logic [DataWidth-1:0]      op2Data1_o,
  output logic [DataWidth-1:0]      op2Data2_o,
  output logic                      opValid3_o,
  output logic [DataWidth-1:0]      op3Data1_o,
  output logic [DataWidth-1:0]      op3Data2_o,
  output logic [NumPhysRegs-1:0]    phyRegRdy_o
);

  import regReadPkg::*;

  logic [NumLanes-1:0]                     instValid;
  logic [NumLanes-1:0][TagWidth-1:0]       src1;
  logic [NumLanes-1:0][TagWidth-1:0]       src2;
  logic [NumLanes-1:0][NumCheckpoints-1:0] instMask;
  logic [NumLanes-1:0]                     bypValid;
  logic [NumLanes-1:0][TagWidth-1:0]       bypDest;
  logic [NumLanes-1:0][DataWidth-1:0]      bypData;
  logic [NumLanes-1:0]                     wrEn;
  logic [NumLanes-1:0]                     unmapValid;
  logic [NumLanes-1:0][TagWidth-1:0]       unmapTag;
  logic [NumLanes-1:0]                     wakeValid;
  logic [NumLanes-1:0][TagWidth-1:0]       wakeTag;
  logic [2*NumLanes-1:0][TagWidth-1:0]     rdAddr;
  logic [2*NumLanes-1:0][DataWidth-1:0]    rdData;
  logic [2*NumLanes-1:0][DataWidth-1:0]    operand;
  logic [NumLanes-1:0]                     opValid;
  logic                                    mispredictEvent;

  // --------------------------------------------------
  // Gather the per-lane ports
  // --------------------------------------------------

  assign instValid  = {instValid3_i, instValid2_i, instValid1_i, instValid0_i};
  assign src1       = {inst3Src1_i, inst2Src1_i, inst1Src1_i, inst0Src1_i};
  assign src2       = {inst3Src2_i, inst2Src2_i, inst1Src2_i, inst0Src2_i};
  assign instMask   = {inst3Mask_i, inst2Mask_i, inst1Mask_i, inst0Mask_i};
  assign bypValid   = {bypassValid3_i, bypassValid2_i, bypassValid1_i, bypassValid0_i};
  assign bypDest    = {bypassDest3_i, bypassDest2_i, bypassDest1_i, bypassDest0_i};
  assign bypData    = {bypassData3_i, bypassData2_i, bypassData1_i, bypassData0_i};
  assign unmapValid = {unmapValid3_i, unmapValid2_i, unmapValid1_i, unmapValid0_i};
  assign unmapTag   = {unmapTag3_i, unmapTag2_i, unmapTag1_i, unmapTag0_i};
  assign wakeValid  = {wakeValid3_i, wakeValid2_i, wakeValid1_i, wakeValid0_i};
  assign wakeTag    = {wakeTag3_i, wakeTag2_i, wakeTag1_i, wakeTag0_i};

  // Results on a squashed path still forward but never reach the file
  assign wrEn = bypValid & {NumLanes{~recoverFlag_i}};

  assign mispredictEvent = ctrlVerified_i & ctrlMispredict_i;

  // Each lane reads its first source on an even port and its second on the odd one
  for (genvar n = 0; n < NumLanes; n++) begin : gLane
    assign rdAddr[2*n]   = src1[n];
    assign rdAddr[2*n+1] = src2[n];
    assign opValid[n] = instValid[n] & ~(mispredictEvent & instMask[n][ctrlCheckpoint_i]);
  end

  // --------------------------------------------------
  // Register file, operand select, ready table
  // --------------------------------------------------

  physRegFile #(
    .NumRegs   (NumPhysRegs),
    .DataWidth (DataWidth)
  ) physRegFile_i (
    .clk      (clk),
    .rdAddr_i (rdAddr),
    .rdData_o (rdData),
    .wrEn_i   (wrEn),
    .wrAddr_i (bypDest),
    .wrData_i (bypData)
  );

  for (genvar p = 0; p < 2*NumLanes; p++) begin : gOperand
    bypassSelect #(
      .NumRegs   (NumPhysRegs),
      .DataWidth (DataWidth)
    ) bypassSelect_i (
      .srcTag_i      (rdAddr[p]),
      .fileData_i    (rdData[p]),
      .bypassValid_i (bypValid),
      .bypassDest_i  (bypDest),
      .bypassData_i  (bypData),
      .operand_o     (operand[p])
    );
  end

  readyTable #(
    .NumRegs     (NumPhysRegs),
    .NumArchRegs (NumArchRegs)
  ) readyTable_i (
    .clk             (clk),
    .rst_i           (rst_i),
    .exceptionFlag_i (exceptionFlag_i),
    .unmapValid_i    (unmapValid),
    .unmapTag_i      (unmapTag),
    .wakeValid_i     (wakeValid),
    .wakeTag_i       (wakeTag),
    .ready_o         (phyRegRdy_o)
  );

  assign {opValid3_o, opValid2_o, opValid1_o, opValid0_o} = opValid;
  assign op0Data1_o = operand[0];
  assign op0Data2_o = operand[1];
  assign op1Data1_o = operand[2];
  assign op1Data2_o = operand[3];
  assign op2Data1_o = operand[4];
  assign op2Data2_o = operand[5];
  assign op3Data1_o = operand[6];
  assign op3Data2_o = operand[7];

  // The branch unit must only resolve checkpoints that exist
  ckptInRange: assert property (
    @(posedge clk) disable iff (rst_i) ctrlVerified_i |-> (ctrlCheckpoint_i < NumCheckpoints)
  ) else $error("regRead: verified branch names checkpoint %0d", ctrlCheckpoint_i);

endmodule

// File: logic/readyTable.sv
// --------------------------------------------------
// Ready-bit scoreboard, one bit per physical register
// Unmap clears, wakeup sets, reset and exception
// restore the architectural pattern
// --------------------------------------------------

`timescale 1ns/1ps

module readyTable #(
  parameter int NumRegs = regReadPkg::DefPhysRegs,
  parameter int NumArchRegs = regReadPkg::DefArchRegs,
  localparam int TagWidth = $clog2(NumRegs)
) (
  input  logic                                           clk,
  input  logic                                           rst_i,
  input  logic                                           exceptionFlag_i,
  input  logic [regReadPkg::NumLanes-1:0]                unmapValid_i,
  input  logic [regReadPkg::NumLanes-1:0][TagWidth-1:0]  unmapTag_i,
  input  logic [regReadPkg::NumLanes-1:0]                wakeValid_i,
  input  logic [regReadPkg::NumLanes-1:0][TagWidth-1:0]  wakeTag_i,
  output logic [NumRegs-1:0]                             ready_o
);

  import regReadPkg::*;

  // The low NumArchRegs bits are set and the rest are clear
  localparam logic [NumRegs-1:0] ArchPattern = (NumRegs'(1) << NumArchRegs) - 1'b1;

  logic [NumRegs-1:0] readyQ;
  logic [NumRegs-1:0] clearMask;
  logic [NumRegs-1:0] setMask;

  // --------------------------------------------------
  // Per-cycle clear and set masks
  // --------------------------------------------------

  always_comb begin
    clearMask = '0;
    setMask   = '0;
    for (int n = 0; n < NumLanes; n++) begin
      if (unmapValid_i[n]) begin
        clearMask[unmapTag_i[n]] = 1'b1;
      end
      if (wakeValid_i[n]) begin
        setMask[wakeTag_i[n]] = 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // State update
  // --------------------------------------------------

  // Clears go first, so a wakeup on the same tag leaves the bit set
  always_ff @(posedge clk) begin
    if (rst_i || exceptionFlag_i) begin
      readyQ <= ArchPattern;
    end else begin
      readyQ <= (readyQ & ~clearMask) | setMask;
    end
  end

  assign ready_o = readyQ;

  // The restore pattern only makes sense when the mapped set fits the file
  archFitsFile: assert property (
    @(posedge clk) disable iff (rst_i) NumArchRegs <= NumRegs
  ) else $error("readyTable: %0d architectural registers exceed %0d physical",
                NumArchRegs, NumRegs);

endmodule

// File: logic/bypassSelect.sv
// --------------------------------------------------
// Operand select for one source tag
// Tag compare against the bypass lanes, data mux
// --------------------------------------------------

`timescale 1ns/1ps

module bypassSelect #(
  parameter int NumRegs = regReadPkg::DefPhysRegs,
  parameter int DataWidth = regReadPkg::DefDataWidth,
  localparam int TagWidth = $clog2(NumRegs)
) (
  input  logic [TagWidth-1:0]                             srcTag_i,
  input  logic [DataWidth-1:0]                            fileData_i,
  input  logic [regReadPkg::NumLanes-1:0]                 bypassValid_i,
  input  logic [regReadPkg::NumLanes-1:0][TagWidth-1:0]   bypassDest_i,
  input  logic [regReadPkg::NumLanes-1:0][DataWidth-1:0]  bypassData_i,
  output logic [DataWidth-1:0]                            operand_o
);

  import regReadPkg::*;

  logic [NumLanes-1:0] match;
  laneIdx_t            hitLane;

  always_comb begin
    for (int n = 0; n < NumLanes; n++) begin
      match[n] = bypassValid_i[n] && (bypassDest_i[n] == srcTag_i);
    end
  end

  // Encode the match vector into the lane that supplies the operand
  always_comb begin
    hitLane = '0;
    for (int n = 0; n < NumLanes; n++) begin
      if (match[n]) begin
        hitLane = laneIdx_t'(n);
      end
    end
  end

  // Forwarded results beat the file, which still holds the older value
  assign operand_o = (|match) ? bypassData_i[hitLane] : fileData_i;

  // Rename hands out each destination tag once, so lanes never collide
  always_comb begin
    assert final ($isunknown(match) || $onehot0(match))
      else $error("bypassSelect: tag %0d matches several bypass lanes", srcTag_i);
  end

endmodule

// File: logic/physRegFile.sv
// --------------------------------------------------
// Flop-based physical register file
// Eight combinational read ports, four write ports
// --------------------------------------------------

`timescale 1ns/1ps

module physRegFile #(
  parameter int NumRegs = regReadPkg::DefPhysRegs,
  parameter int DataWidth = regReadPkg::DefDataWidth,
  localparam int TagWidth = $clog2(NumRegs),
  localparam int NumRdPorts = 2 * regReadPkg::NumLanes
) (
  input  logic                                            clk,
  input  logic [NumRdPorts-1:0][TagWidth-1:0]             rdAddr_i,
  output logic [NumRdPorts-1:0][DataWidth-1:0]            rdData_o,
  input  logic [regReadPkg::NumLanes-1:0]                 wrEn_i,
  input  logic [regReadPkg::NumLanes-1:0][TagWidth-1:0]   wrAddr_i,
  input  logic [regReadPkg::NumLanes-1:0][DataWidth-1:0]  wrData_i
);

  import regReadPkg::*;

  logic [DataWidth-1:0] regs [NumRegs];

  logic [NumRegs-1:0] wrHit;
  laneIdx_t           wrSel [NumRegs];

  // --------------------------------------------------
  // Write decode
  // --------------------------------------------------

  // Lanes are scanned in order, so a later lane on the same tag takes over
  always_comb begin
    for (int r = 0; r < NumRegs; r++) begin
      wrHit[r] = 1'b0;
      wrSel[r] = '0;
      for (int n = 0; n < NumLanes; n++) begin
        if (wrEn_i[n] && (wrAddr_i[n] == TagWidth'(r))) begin
          wrHit[r] = 1'b1;
          wrSel[r] = laneIdx_t'(n);
        end
      end
    end
  end

  // Each written register takes the data of its winning lane at the edge
  always_ff @(posedge clk) begin
    for (int r = 0; r < NumRegs; r++) begin
      if (wrHit[r]) begin
        regs[r] <= wrData_i[wrSel[r]];
      end
    end
  end

  // --------------------------------------------------
  // Read ports
  // --------------------------------------------------

  // A write at this edge shows up here only from the next cycle on
  always_comb begin
    for (int p = 0; p < NumRdPorts; p++) begin
      rdData_o[p] = regs[rdAddr_i[p]];
    end
  end

  // Every enabled write must name a register inside the file
  for (genvar n = 0; n < NumLanes; n++) begin : gWrCheck
    wrAddrInRange: assert property (
      @(posedge clk) wrEn_i[n] |-> (wrAddr_i[n] < NumRegs)
    ) else $error("physRegFile: lane %0d writes tag %0d beyond the file", n, wrAddr_i[n]);
  end

endmodule

// File: logic/regReadPkg.sv
// --------------------------------------------------
// Shared constants for the register-read stage
// Lane count, default sizes and the lane index type
// --------------------------------------------------

package regReadPkg;

  // Port names carry the lane number, so the lane count is fixed
  localparam int NumLanes = 4;

  // Default sizes that the top level overrides with its own values
  localparam int DefPhysRegs = 64;

  // Registers holding architectural state, ready after reset
  localparam int DefArchRegs = 32;

  localparam int DefDataWidth = 32;

  // Also the width of an instruction's checkpoint mask
  localparam int DefCheckpoints = 4;

  // Index of an issue or bypass lane
  typedef logic [$clog2(NumLanes)-1:0] laneIdx_t;

endpackage
